/* hw/wh_pkg.sv */
package wh_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // link and header widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int flit_width_c = 32;
  localparam int cord_width_c = 4;
  localparam int len_width_c  = 3;
  localparam int cid_width_c  = 2;

  // header field offsets, cord sits at bit 0
  localparam int len_lsb_c = cord_width_c;
  localparam int cid_lsb_c = cord_width_c + len_width_c;

  typedef logic [flit_width_c-1:0] flit_t;
  typedef logic [cord_width_c-1:0] cord_t;
  typedef logic [len_width_c-1:0]  len_t;
  typedef logic [cid_width_c-1:0]  cid_t;

  // wormhole state, shared by both concentrator halves
  typedef enum logic {
    e_hdr,
    e_body
  } conc_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // header field access
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // number of body flits behind this header
  function automatic len_t hdr_len_f(flit_t flit);
    return flit[len_lsb_c +: len_width_c];
  endfunction

  // concentrator id of the sending link
  function automatic cid_t hdr_cid_f(flit_t flit);
    return flit[cid_lsb_c +: cid_width_c];
  endfunction

endpackage

/* hw/wh_fifo.sv */
`timescale 1ns/1ns

module wh_fifo
  import wh_pkg::*;
  (input  logic    mem_clk_i
   , input  logic  reset_i

   , input  flit_t data_i
   , input  logic  v_i
   , output logic  ready_o

   , output flit_t data_o
   , output logic  v_o
   , input  logic  ready_i
   );

  // main slot drives the output, skid slot catches a flit
  // that arrives while the main slot is stalled
  flit_t main_data_r;
  flit_t skid_data_r;
  logic  main_v_r;
  logic  skid_v_r;
  logic  enq;
  logic  deq;
  logic  main_load;

  // ready comes from a register, so the link never sees ready_i
  assign ready_o = ~skid_v_r;
  assign data_o  = main_data_r;
  assign v_o     = main_v_r;

  assign enq       = v_i & ready_o;
  assign deq       = main_v_r & ready_i;
  assign main_load = ~main_v_r | deq;

  always_ff @(posedge mem_clk_i) begin
    if (reset_i) begin
      main_v_r <= 1'b0;
      skid_v_r <= 1'b0;
    end else if (main_load) begin
      // skid drains first to keep flit order
      if (skid_v_r) begin
        main_v_r <= 1'b1;
        skid_v_r <= 1'b0;
      end else begin
        main_v_r <= enq;
      end
    end else if (enq) begin
      skid_v_r <= 1'b1;
    end
  end

  always_ff @(posedge mem_clk_i) begin
    if (main_load) begin
      main_data_r <= skid_v_r ? skid_data_r : data_i;
    end
    if (~main_load & enq) begin
      skid_data_r <= data_i;
    end
  end

endmodule

/* hw/wh_concentrator_in.sv */
`timescale 1ns/1ns

module wh_concentrator_in
  import wh_pkg::*;
  #(parameter int num_in_p = 4)
  (input  logic                    mem_clk_i
   , input  logic                  reset_i

   , input  flit_t [num_in_p-1:0]  data_i
   , input  logic  [num_in_p-1:0]  v_i
   , output logic  [num_in_p-1:0]  ready_o

   , output flit_t                 data_o
   , output logic                  v_o
   , input  logic                  ready_i
   );

  localparam int sel_width_lp = $clog2(num_in_p);

  typedef logic [sel_width_lp-1:0] sel_t;
  // one extra bit so pointer plus offset cannot wrap early
  typedef logic [sel_width_lp:0]   sel_wide_t;

  conc_state_e state_r;
  sel_t        ptr_r;
  sel_t        grant_r;
  len_t        cnt_r;
  sel_t        pick;
  sel_t        sel;
  sel_t        sel_next;
  logic        found;
  logic        xfer;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // round-robin pick, first valid at or after ptr_r
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin : arb
    sel_wide_t k;
    pick  = ptr_r;
    found = 1'b0;
    for (int i = 0; i < num_in_p; i++) begin
      k = sel_wide_t'(ptr_r) + sel_wide_t'(i);
      if (k >= sel_wide_t'(num_in_p)) begin
        k = k - sel_wide_t'(num_in_p);
      end
      if (!found && v_i[k[sel_width_lp-1:0]]) begin
        pick  = k[sel_width_lp-1:0];
        found = 1'b1;
      end
    end
  end

  // body flits come only from the input holding the grant
  assign sel = (state_r == e_body) ? grant_r : pick;

  // pointer moves just past whichever input finished a packet
  assign sel_next = (sel == sel_t'(num_in_p - 1)) ? '0 : sel + 1'b1;

  assign data_o = data_i[sel];
  assign v_o    = (state_r == e_body) ? v_i[grant_r] : found;
  assign xfer   = v_o & ready_i;

  always_comb begin
    ready_o      = '0;
    ready_o[sel] = ready_i;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // wormhole state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge mem_clk_i) begin
    if (reset_i) begin
      state_r <= e_hdr;
      ptr_r   <= '0;
      grant_r <= '0;
      cnt_r   <= '0;
    end else if (xfer) begin
      case (state_r)
        e_hdr: begin
          grant_r <= pick;
          cnt_r   <= hdr_len_f(data_o);
          // header-only packet releases the link at once
          if (hdr_len_f(data_o) != '0) begin
            state_r <= e_body;
          end else begin
            ptr_r <= sel_next;
          end
        end
        e_body: begin
          cnt_r <= cnt_r - 1'b1;
          if (cnt_r == len_t'(1)) begin
            state_r <= e_hdr;
            ptr_r   <= sel_next;
          end
        end
        default: begin
          state_r <= e_hdr;
        end
      endcase
    end else if (state_r == e_hdr && found) begin
      // a stalled header keeps its input first in line
      ptr_r <= pick;
    end
  end

endmodule

/* hw/wh_concentrator_out.sv */
`timescale 1ns/1ns

module wh_concentrator_out
  import wh_pkg::*;
  #(parameter int num_in_p = 4)
  (input  logic                    mem_clk_i
   , input  logic                  reset_i

   , input  flit_t                 data_i
   , input  logic                  v_i
   , output logic                  ready_o

   , output flit_t [num_in_p-1:0]  data_o
   , output logic  [num_in_p-1:0]  v_o
   , input  logic  [num_in_p-1:0]  ready_i
   );

  localparam int sel_width_lp = $clog2(num_in_p);

  typedef logic [sel_width_lp-1:0] sel_t;

  conc_state_e state_r;
  sel_t        route_r;
  len_t        cnt_r;
  sel_t        hdr_route;
  sel_t        dest;
  logic        xfer;

  // cid beyond the last link folds onto the last link
  always_comb begin : cid_route
    cid_t cid;
    cid = hdr_cid_f(data_i);
    if (int'(cid) >= num_in_p) begin
      hdr_route = sel_t'(num_in_p - 1);
    end else begin
      hdr_route = sel_t'(cid);
    end
  end

  assign dest = (state_r == e_body) ? route_r : hdr_route;

  // data fans out to every link, valid marks the one it is for
  assign data_o  = {num_in_p{data_i}};
  assign ready_o = ready_i[dest];
  assign xfer    = v_i & ready_o;

  always_comb begin
    v_o       = '0;
    v_o[dest] = v_i;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // route held until the last body flit
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge mem_clk_i) begin
    if (reset_i) begin
      state_r <= e_hdr;
      route_r <= '0;
      cnt_r   <= '0;
    end else if (xfer) begin
      if (state_r == e_hdr) begin
        route_r <= hdr_route;
        cnt_r   <= hdr_len_f(data_i);
        if (hdr_len_f(data_i) != '0) begin
          state_r <= e_body;
        end
      end else begin
        cnt_r <= cnt_r - 1'b1;
        if (cnt_r == len_t'(1)) begin
          state_r <= e_hdr;
        end
      end
    end
  end

endmodule

/* hw/mem_complex.sv */
`timescale 1ns/1ns

module mem_complex
  import wh_pkg::*;
  #(parameter int num_in_p = 4)
  (input  logic                    mem_clk_i
   , input  logic                  reset_i

   // command links from the tiles
   , input  flit_t [num_in_p-1:0]  mem_cmd_data_i
   , input  logic  [num_in_p-1:0]  mem_cmd_v_i
   , output logic  [num_in_p-1:0]  mem_cmd_ready_o

   // concentrated link toward DRAM
   , output flit_t                 dram_cmd_data_o
   , output logic                  dram_cmd_v_o
   , input  logic                  dram_cmd_ready_i

   , input  flit_t                 dram_resp_data_i
   , input  logic                  dram_resp_v_i
   , output logic                  dram_resp_ready_o

   // response links back to the tiles
   , output flit_t [num_in_p-1:0]  mem_resp_data_o
   , output logic  [num_in_p-1:0]  mem_resp_v_o
   , input  logic  [num_in_p-1:0]  mem_resp_ready_i
   );

  flit_t [num_in_p-1:0] cmd_data;
  logic  [num_in_p-1:0] cmd_v;
  logic  [num_in_p-1:0] cmd_ready;
  flit_t                resp_data;
  logic                 resp_v;
  logic                 resp_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // command path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < num_in_p; i++) begin : g_cmd
    wh_fifo cmd_fifo
      (.mem_clk_i(mem_clk_i)
       ,.reset_i(reset_i)
       ,.data_i(mem_cmd_data_i[i])
       ,.v_i(mem_cmd_v_i[i])
       ,.ready_o(mem_cmd_ready_o[i])
       ,.data_o(cmd_data[i])
       ,.v_o(cmd_v[i])
       ,.ready_i(cmd_ready[i])
       );
  end

  wh_concentrator_in
    #(.num_in_p(num_in_p))
    conc_in
    (.mem_clk_i(mem_clk_i)
     ,.reset_i(reset_i)
     ,.data_i(cmd_data)
     ,.v_i(cmd_v)
     ,.ready_o(cmd_ready)
     ,.data_o(dram_cmd_data_o)
     ,.v_o(dram_cmd_v_o)
     ,.ready_i(dram_cmd_ready_i)
     );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  wh_fifo resp_fifo
    (.mem_clk_i(mem_clk_i)
     ,.reset_i(reset_i)
     ,.data_i(dram_resp_data_i)
     ,.v_i(dram_resp_v_i)
     ,.ready_o(dram_resp_ready_o)
     ,.data_o(resp_data)
     ,.v_o(resp_v)
     ,.ready_i(resp_ready)
     );

  wh_concentrator_out
    #(.num_in_p(num_in_p))
    conc_out
    (.mem_clk_i(mem_clk_i)
     ,.reset_i(reset_i)
     ,.data_i(resp_data)
     ,.v_i(resp_v)
     ,.ready_o(resp_ready)
     ,.data_o(mem_resp_data_o)
     ,.v_o(mem_resp_v_o)
     ,.ready_i(mem_resp_ready_i)
     );

endmodule

/* bench/mem_complex_assert.sv */
`timescale 1ns/1ns

module mem_complex_assert
  import wh_pkg::*;
  #(parameter int num_in_p = 4)
  (input  logic                          mem_clk_i
   , input  logic                        reset_i
   , input  flit_t                       cmd_data_i
   , input  logic                        cmd_v_i
   , input  logic                        cmd_ready_i
   , input  conc_state_e                 state_i
   , input  logic [$clog2(num_in_p)-1:0] grant_i
   );

  // body flits still owed by the packet on dram_cmd
  len_t body_left_r;
  logic xfer;
  int   fail_cnt = 0;

  assign xfer = cmd_v_i & cmd_ready_i;

  always_ff @(posedge mem_clk_i) begin
    if (reset_i) begin
      body_left_r <= '0;
    end else if (xfer) begin
      if (body_left_r == '0) begin
        // len field by the header layout
        body_left_r <= len_t'(cmd_data_i[6:4]);
      end else begin
        body_left_r <= body_left_r - 1'b1;
      end
    end
  end

  // a stalled flit stays put until DRAM takes it
  hold_a: assert property (@(posedge mem_clk_i) disable iff (reset_i)
    cmd_v_i && !cmd_ready_i |=> cmd_v_i && $stable(cmd_data_i))
    else begin
      $error("dram_cmd flit dropped or changed while stalled");
      fail_cnt++;
    end

  // body flits come from one input only, up to the count in the header
  grant_a: assert property (@(posedge mem_clk_i) disable iff (reset_i)
    body_left_r != '0 && !(xfer && body_left_r == len_t'(1))
    |=> state_i == e_body && $stable(grant_i))
    else begin
      $error("grant moved or body ended early inside a packet");
      fail_cnt++;
    end

  reset_a: assert property (@(posedge mem_clk_i) reset_i |=> !cmd_v_i)
    else begin
      $error("dram_cmd valid high right after reset");
      fail_cnt++;
    end

endmodule

bind wh_concentrator_in mem_complex_assert #(.num_in_p(num_in_p)) conc_in_chk
  (.mem_clk_i(mem_clk_i)
   ,.reset_i(reset_i)
   ,.cmd_data_i(data_o)
   ,.cmd_v_i(v_o)
   ,.cmd_ready_i(ready_i)
   ,.state_i(state_r)
   ,.grant_i(grant_r)
   );

/* bench/mem_complex_tb.sv */
`timescale 1ns/1ns

module mem_complex_tb
  import wh_pkg::*;
  ();

  localparam int num_in_c = 4;
  // longest run is a few hundred cycles, this leaves a wide margin
  localparam int timeout_c = 4000;

  logic mem_clk_i = 1'b0;
  logic reset_i = 1'b1;
  flit_t [num_in_c-1:0] cmd_data;
  logic [num_in_c-1:0] cmd_v, cmd_ready, resp_v, resp_ready;
  flit_t [num_in_c-1:0] resp_data;
  flit_t dram_cmd_data, dram_resp_data;
  logic dram_cmd_v, dram_cmd_ready, dram_resp_v, dram_resp_ready;

  flit_t cmd_q [num_in_c][$];
  flit_t resp_q [num_in_c][$];
  flit_t dram_q [$];
  cid_t hdr_order [$];
  int err_value = 0;
  int err_other = 0;
  int cycle_cnt = 0;
  logic stall_en = 1'b0;
  logic in_body = 1'b0;
  logic resp_taken = 1'b0;
  len_t rem;
  cid_t cur_link;

  mem_complex #(.num_in_p(num_in_c)) mem_complex_i
    (.mem_clk_i(mem_clk_i), .reset_i(reset_i)
     ,.mem_cmd_data_i(cmd_data), .mem_cmd_v_i(cmd_v), .mem_cmd_ready_o(cmd_ready)
     ,.dram_cmd_data_o(dram_cmd_data), .dram_cmd_v_o(dram_cmd_v)
     ,.dram_cmd_ready_i(dram_cmd_ready)
     ,.dram_resp_data_i(dram_resp_data), .dram_resp_v_i(dram_resp_v)
     ,.dram_resp_ready_o(dram_resp_ready)
     ,.mem_resp_data_o(resp_data), .mem_resp_v_o(resp_v), .mem_resp_ready_i(resp_ready)
     );

  always #2 mem_clk_i = ~mem_clk_i;

  always @(posedge mem_clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_c) begin
      $display("timeout, flits still outstanding after %0d cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_flit(string name, flit_t got, flit_t exp);
    if (got !== exp) begin
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
      err_value++;
    end
  endtask

  task automatic check_cid(string name, cid_t got, cid_t exp);
    if (got !== exp) begin
      $display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
      err_value++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // DRAM model and link monitors, sampled mid-cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge mem_clk_i) begin
    resp_taken = !reset_i && dram_resp_v && dram_resp_ready;
    if (reset_i) begin
      in_body = 1'b0;
    end else if (dram_cmd_v && dram_cmd_ready) begin
      if (!in_body) begin
        // header fields by the documented bit layout
        cur_link = dram_cmd_data[8:7];
        rem = dram_cmd_data[6:4];
        hdr_order.push_back(cur_link);
      end else begin
        rem = rem - 1'b1;
      end
      in_body = (rem != '0);
      if (cmd_q[cur_link].size() == 0) begin
        $display("dram_cmd carried a flit that link %0d never sent", cur_link);
        err_other++;
      end else begin
        check_flit("dram_cmd_data_o", dram_cmd_data, cmd_q[cur_link].pop_front());
      end
      dram_q.push_back(dram_cmd_data ^ 32'h8000_0000);
    end
    for (int i = 0; i < num_in_c; i++) begin
      if (!reset_i && resp_v[i] && resp_ready[i]) begin
        if (resp_q[i].size() == 0) begin
          $display("mem_resp link %0d returned a flit nobody asked for", i);
          err_other++;
        end else begin
          check_flit($sformatf("mem_resp_data_o[%0d]", i), resp_data[i], resp_q[i].pop_front());
        end
      end
    end
  end

  always @(posedge mem_clk_i) begin
    #1;
    if (resp_taken) begin
      void'(dram_q.pop_front());
    end
    resp_taken = 1'b0;
    dram_resp_v = (dram_q.size() != 0);
    dram_resp_data = (dram_q.size() != 0) ? dram_q[0] : '0;
    dram_cmd_ready = !stall_en || ($urandom % 4 != 0);
    for (int i = 0; i < num_in_c; i++) begin
      resp_ready[i] = !stall_en || ($urandom % 3 != 0);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // link drivers, called 1 ns after a rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic send_flit(int link, flit_t flit);
    logic done;
    done = 1'b0;
    cmd_data[link] = flit;
    cmd_v[link] = 1'b1;
    while (!done) begin
      @(negedge mem_clk_i);
      done = cmd_ready[link];
      @(posedge mem_clk_i);
      #1;
    end
    cmd_v[link] = 1'b0;
  endtask

  task automatic send_packet(int link, int len);
    flit_t flit;
    flit = {23'($urandom), cid_t'(link), len_t'(len), cord_t'($urandom)};
    for (int i = 0; i <= len; i++) begin
      if (i > 0) begin
        flit = flit_t'($urandom);
      end
      cmd_q[link].push_back(flit);
      resp_q[link].push_back(flit ^ 32'h8000_0000);
      send_flit(link, flit);
    end
  endtask

  task automatic send_stream(int link, int count);
    repeat (count) send_packet(link, $urandom % 8);
  endtask

  function automatic logic queues_empty();
    logic empty;
    empty = (dram_q.size() == 0);
    for (int i = 0; i < num_in_c; i++) begin
      empty &= (cmd_q[i].size() == 0) && (resp_q[i].size() == 0);
    end
    return empty;
  endfunction

  task automatic wait_drain();
    while (!queues_empty()) @(posedge mem_clk_i);
    @(posedge mem_clk_i);
    #1;
  endtask

  task automatic apply_reset();
    reset_i = 1'b1;
    repeat (4) @(posedge mem_clk_i);
    #1;
    reset_i = 1'b0;
    hdr_order.delete();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_single_hdr();
    send_packet(2, 0);
    wait_drain();
  endtask

  // all links at once right after reset, grant order starts at 0
  task automatic test_all_links();
    apply_reset();
    fork
      send_packet(0, 3);
      send_packet(1, 3);
      send_packet(2, 3);
      send_packet(3, 3);
    join
    wait_drain();
    if (hdr_order.size() != num_in_c) begin
      $display("expected 4 headers on dram_cmd, saw %0d", hdr_order.size());
      err_other++;
    end
    for (int i = 0; i < num_in_c && i < hdr_order.size(); i++) begin
      check_cid("dram_cmd header cid", hdr_order[i], cid_t'(i));
    end
  endtask

  task automatic test_stalls();
    stall_en = 1'b1;
    fork
      send_stream(0, 5);
      send_stream(1, 5);
      send_stream(2, 5);
      send_stream(3, 5);
    join
    wait_drain();
    stall_en = 1'b0;
  endtask

  task automatic test_lengths();
    hdr_order.delete();
    for (int len = 0; len < 8; len++) begin
      send_packet(1, len);
    end
    wait_drain();
    if (hdr_order.size() != 8) begin
      $display("expected 8 headers from link 1, saw %0d", hdr_order.size());
      err_other++;
    end
    foreach (hdr_order[i]) check_cid("dram_cmd header cid", hdr_order[i], cid_t'(1));
  endtask

  initial begin
    int assert_fails;
    void'($urandom(32'he2603654));
    cmd_data = '0;
    cmd_v = '0;
    dram_cmd_ready = 1'b1;
    dram_resp_data = '0;
    dram_resp_v = 1'b0;
    resp_ready = '1;
    apply_reset();
    test_single_hdr();
    test_all_links();
    test_stalls();
    test_lengths();
    assert_fails = mem_complex_i.conc_in.conc_in_chk.fail_cnt;
    $display("errors: %0d wrong values, %0d lost or extra flits, %0d assertion failures",
             err_value, err_other, assert_fails);
    if (err_value + err_other + assert_fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
hw/wh_pkg.sv
hw/wh_fifo.sv
hw/wh_concentrator_in.sv
hw/wh_concentrator_out.sv
hw/mem_complex.sv
bench/mem_complex_assert.sv
bench/mem_complex_tb.sv
